// File: verilog/llc_pkg.sv
// llc package
// cache geometry, address field widths and the types shared by the cache blocks
package llc_pkg;

  // geometry
  localparam int unsigned ADDR_W = 16;  // byte address
  localparam int unsigned DATA_W = 32;  // one block is one word
  localparam int unsigned WAYS   = 2;
  localparam int unsigned SETS   = 16;
  localparam int unsigned BLOCKS = 4;   // words per line

  // address fields, tag | index | block | byte
  localparam int unsigned INDEX_W = $clog2(SETS);
  localparam int unsigned BLOCK_W = $clog2(BLOCKS);
  localparam int unsigned BYTE_W  = $clog2(DATA_W / 8);
  localparam int unsigned TAG_W   = ADDR_W - INDEX_W - BLOCK_W - BYTE_W;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [BLOCK_W-1:0] block_t;

  // one tag store entry
  typedef struct packed {
    tag_t tag;
    logic valid;
    logic dirty;
  } tag_entry_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT_RD,
    EVICT_WR,
    REFILL,
    ACCESS,
    DONE
  } llc_state_e;

endpackage

// File: verilog/llc_sram.sv
// single-port storage array
// synchronous write, registered read that holds until the next enabled read
`timescale 1ns/100ps

module llc_sram #(
  parameter type         word_t = logic,
  parameter int unsigned DEPTH  = 16
) (
  input  logic                                       clk_i,
  input  logic                                       en_i,
  input  logic                                       we_i,
  input  logic [(DEPTH > 1 ? $clog2(DEPTH) : 1)-1:0] addr_i,
  input  word_t                                      wdata_i,
  output word_t                                      rdata_o
);

  word_t mem_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];  // read port only updates on a read
      end
    end
  end

endmodule

// File: verilog/llc_tag_store.sv
// tag store for all ways
// holds tag/dirty entries, valid and LRU bits; reports hit and victim
// one cycle after a lookup strobe
`timescale 1ns/100ps

module llc_tag_store (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            lookup_i,
  input  llc_pkg::index_t index_i,
  input  llc_pkg::tag_t   tag_i,
  input  logic            update_i,
  input  logic            update_way_i,
  input  logic            set_dirty_i,
  output logic            hit_o,
  output logic            hit_way_o,
  output logic            victim_way_o,
  output logic            victim_dirty_o,
  output llc_pkg::tag_t   victim_tag_o
);
  import llc_pkg::*;

  logic [WAYS-1:0][SETS-1:0] valid_q;
  logic [SETS-1:0]           lru_q;     // names the least recently used way
  index_t                    index_q;   // set of the last lookup

  tag_entry_t      rd_entry [WAYS];
  tag_entry_t      wr_entry;
  logic [WAYS-1:0] way_valid;
  logic [WAYS-1:0] way_hit;
  logic            keep_dirty;

  // a hit line that is rewritten keeps its dirty bit
  assign keep_dirty = hit_o && (hit_way_o == update_way_i) && rd_entry[update_way_i].dirty;

  assign wr_entry = '{tag: tag_i, valid: 1'b1, dirty: set_dirty_i | keep_dirty};

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    llc_sram #(
      .word_t  ( tag_entry_t ),
      .DEPTH   ( SETS        )
    ) i_tag_sram (
      .clk_i   ( clk_i                                          ),
      .en_i    ( lookup_i || (update_i && update_way_i == 1'(w)) ),
      .we_i    ( update_i && update_way_i == 1'(w)               ),
      .addr_i  ( index_i                                        ),
      .wdata_i ( wr_entry                                       ),
      .rdata_o ( rd_entry[w]                                    )
    );
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      way_valid[w] = valid_q[w][index_q] & rd_entry[w].valid;
      way_hit[w]   = way_valid[w] & (rd_entry[w].tag == tag_i);
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];

  // an empty way first, else the LRU way
  assign victim_way_o   = !way_valid[0] ? 1'b0 :
                          !way_valid[1] ? 1'b1 : lru_q[index_q];
  assign victim_dirty_o = way_valid[victim_way_o] & rd_entry[victim_way_o].dirty;
  assign victim_tag_o   = rd_entry[victim_way_o].tag;

  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      index_q <= index_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      lru_q   <= '0;
    end else if (update_i) begin
      valid_q[update_way_i][index_q] <= 1'b1;
      lru_q[index_q]                 <= ~update_way_i;  // other way is now LRU
    end
  end

endmodule

// File: verilog/llc_data_ways.sv
// data storage for all ways
// one array per way, addressed by set and block; only the selected way is enabled
`timescale 1ns/100ps

module llc_data_ways (
  input  logic            clk_i,
  input  logic            en_i,
  input  logic            we_i,
  input  logic            way_i,
  input  llc_pkg::index_t index_i,
  input  llc_pkg::block_t block_i,
  input  llc_pkg::data_t  wdata_i,
  output llc_pkg::data_t  rdata_o
);
  import llc_pkg::*;

  data_t way_rdata [WAYS];
  logic  rd_way_q;  // way of the last read

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    llc_sram #(
      .word_t  ( data_t        ),
      .DEPTH   ( SETS * BLOCKS )
    ) i_data_sram (
      .clk_i   ( clk_i                       ),
      .en_i    ( en_i && (way_i == 1'(w))    ),
      .we_i    ( we_i                        ),
      .addr_i  ( {index_i, block_i}          ),
      .wdata_i ( wdata_i                     ),
      .rdata_o ( way_rdata[w]                )
    );
  end

  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rd_way_q <= way_i;
    end
  end

  assign rdata_o = way_rdata[rd_way_q];

endmodule

// File: verilog/llc_block_cnt.sv
// block offset counter
// walks the words of one line for eviction and refill, wraps after the last
`timescale 1ns/100ps

module llc_block_cnt (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            clear_i,
  input  logic            step_i,
  output llc_pkg::block_t block_o,
  output logic            last_o
);
  import llc_pkg::*;

  block_t block_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      block_q <= '0;
    end else if (clear_i) begin  // clear wins over step
      block_q <= '0;
    end else if (step_i) begin
      block_q <= block_q + 1'b1;  // wraps to zero
    end
  end

  assign block_o = block_q;
  assign last_o  = (block_q == block_t'(BLOCKS - 1));

endmodule

// File: verilog/llc_ctrl.sv
// cache controller FSM
// sequences lookup, dirty eviction, line refill and the final word access
// for one CPU request at a time
`timescale 1ns/100ps

module llc_ctrl (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // CPU side
  input  logic            cpu_req_i,
  input  logic            cpu_we_i,
  input  llc_pkg::addr_t  cpu_addr_i,
  input  llc_pkg::data_t  cpu_wdata_i,
  output logic            cpu_done_o,
  output llc_pkg::data_t  cpu_rdata_o,
  // memory side
  output logic            mem_req_o,
  output logic            mem_we_o,
  output llc_pkg::addr_t  mem_addr_o,
  output llc_pkg::data_t  mem_wdata_o,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  llc_pkg::data_t  mem_rdata_i,
  // tag store
  output logic            lookup_o,
  input  logic            hit_i,
  input  logic            hit_way_i,
  input  logic            victim_way_i,
  input  logic            victim_dirty_i,
  input  llc_pkg::tag_t   victim_tag_i,
  output logic            update_o,
  output logic            update_way_o,
  output logic            set_dirty_o,
  // data ways
  output logic            data_en_o,
  output logic            data_we_o,
  output logic            data_way_o,
  output llc_pkg::block_t data_block_o,
  output llc_pkg::data_t  data_wdata_o,
  input  llc_pkg::data_t  data_rdata_i,
  // block counter
  output logic            cnt_clear_o,
  output logic            cnt_step_o,
  input  llc_pkg::block_t cnt_block_i,
  input  logic            cnt_last_i
);
  import llc_pkg::*;

  llc_state_e state_q, state_d;
  logic       wait_q;       // refill read granted, data not yet back
  logic       way_q;        // way chosen at lookup
  tag_t       evict_tag_q;

  tag_t   cpu_tag;
  index_t cpu_index;
  block_t cpu_block;
  tag_t   line_tag;

  assign {cpu_tag, cpu_index, cpu_block} = cpu_addr_i[ADDR_W-1:BYTE_W];

  assign line_tag    = (state_q == EVICT_WR) ? evict_tag_q : cpu_tag;
  assign mem_addr_o  = {line_tag, cpu_index, cnt_block_i, {BYTE_W{1'b0}}};
  assign mem_wdata_o = data_rdata_i;  // evicted word, held by the data ways

  assign cpu_done_o  = (state_q == DONE);
  assign cpu_rdata_o = data_rdata_i;  // word read in ACCESS

  assign data_way_o   = way_q;
  assign update_way_o = way_q;
  assign set_dirty_o  = cpu_we_i;

  always_comb begin
    state_d      = state_q;
    lookup_o     = 1'b0;
    update_o     = 1'b0;
    mem_req_o    = 1'b0;
    mem_we_o     = 1'b0;
    data_en_o    = 1'b0;
    data_we_o    = 1'b0;
    data_block_o = cnt_block_i;
    data_wdata_o = mem_rdata_i;
    cnt_clear_o  = 1'b0;
    cnt_step_o   = 1'b0;
    case (state_q)
      IDLE: begin
        if (cpu_req_i) begin
          lookup_o = 1'b1;
          state_d  = LOOKUP;
        end
      end
      LOOKUP: begin
        cnt_clear_o = 1'b1;
        if (hit_i) begin
          state_d = ACCESS;
        end else if (victim_dirty_i) begin
          state_d = EVICT_RD;
        end else begin
          state_d = REFILL;
        end
      end
      EVICT_RD: begin
        data_en_o = 1'b1;  // fetch the victim word
        state_d   = EVICT_WR;
      end
      EVICT_WR: begin
        mem_req_o = 1'b1;
        mem_we_o  = 1'b1;
        if (mem_gnt_i) begin
          cnt_step_o = 1'b1;
          state_d    = cnt_last_i ? REFILL : EVICT_RD;
        end
      end
      REFILL: begin
        mem_req_o = !wait_q;
        if (mem_rvalid_i) begin
          data_en_o  = 1'b1;
          data_we_o  = 1'b1;
          cnt_step_o = 1'b1;
          if (cnt_last_i) begin
            state_d = ACCESS;
          end
        end
      end
      ACCESS: begin
        data_en_o    = 1'b1;
        data_we_o    = cpu_we_i;
        data_block_o = cpu_block;
        data_wdata_o = cpu_wdata_i;
        update_o     = 1'b1;  // tag, valid, dirty and LRU
        state_d      = DONE;
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      wait_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_req_o && mem_gnt_i && !mem_we_o) begin
        wait_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // hit way or victim, and the tag to write back under
  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP) begin
      way_q       <= hit_i ? hit_way_i : victim_way_i;
      evict_tag_q <= victim_tag_i;
    end
  end

endmodule

// File: verilog/llc_top.sv
// last-level cache top
// 2-way write-back cache between a CPU word port and a memory word port
`timescale 1ns/100ps

module llc_top (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // CPU side
  input  logic           cpu_req_i,
  input  logic           cpu_we_i,
  input  llc_pkg::addr_t cpu_addr_i,
  input  llc_pkg::data_t cpu_wdata_i,
  output logic           cpu_done_o,
  output llc_pkg::data_t cpu_rdata_o,
  // memory side
  output logic           mem_req_o,
  output logic           mem_we_o,
  output llc_pkg::addr_t mem_addr_o,
  output llc_pkg::data_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  llc_pkg::data_t mem_rdata_i
);
  import llc_pkg::*;

  // tag store
  logic   lookup, hit, hit_way, victim_way, victim_dirty;
  tag_t   victim_tag;
  logic   update, update_way, set_dirty;

  // data ways
  logic   data_en, data_we, data_way;
  block_t data_block;
  data_t  data_wdata, data_rdata;

  // counter
  logic   cnt_clear, cnt_step, cnt_last;
  block_t cnt_block;

  llc_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .cpu_req_i      ( cpu_req_i      ),
    .cpu_we_i       ( cpu_we_i       ),
    .cpu_addr_i     ( cpu_addr_i     ),
    .cpu_wdata_i    ( cpu_wdata_i    ),
    .cpu_done_o     ( cpu_done_o     ),
    .cpu_rdata_o    ( cpu_rdata_o    ),
    .mem_req_o      ( mem_req_o      ),
    .mem_we_o       ( mem_we_o       ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_rvalid_i   ( mem_rvalid_i   ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .lookup_o       ( lookup         ),
    .hit_i          ( hit            ),
    .hit_way_i      ( hit_way        ),
    .victim_way_i   ( victim_way     ),
    .victim_dirty_i ( victim_dirty   ),
    .victim_tag_i   ( victim_tag     ),
    .update_o       ( update         ),
    .update_way_o   ( update_way     ),
    .set_dirty_o    ( set_dirty      ),
    .data_en_o      ( data_en        ),
    .data_we_o      ( data_we        ),
    .data_way_o     ( data_way       ),
    .data_block_o   ( data_block     ),
    .data_wdata_o   ( data_wdata     ),
    .data_rdata_i   ( data_rdata     ),
    .cnt_clear_o    ( cnt_clear      ),
    .cnt_step_o     ( cnt_step       ),
    .cnt_block_i    ( cnt_block      ),
    .cnt_last_i     ( cnt_last       )
  );

  llc_block_cnt i_block_cnt (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .clear_i ( cnt_clear ),
    .step_i  ( cnt_step  ),
    .block_o ( cnt_block ),
    .last_o  ( cnt_last  )
  );

  // set index and tag come straight from the held CPU address
  llc_tag_store i_tag_store (
    .clk_i          ( clk_i                                      ),
    .rst_n_i        ( rst_n_i                                    ),
    .lookup_i       ( lookup                                     ),
    .index_i        ( cpu_addr_i[BYTE_W+BLOCK_W +: INDEX_W]      ),
    .tag_i          ( cpu_addr_i[ADDR_W-1 -: TAG_W]              ),
    .update_i       ( update                                     ),
    .update_way_i   ( update_way                                 ),
    .set_dirty_i    ( set_dirty                                  ),
    .hit_o          ( hit                                        ),
    .hit_way_o      ( hit_way                                    ),
    .victim_way_o   ( victim_way                                 ),
    .victim_dirty_o ( victim_dirty                               ),
    .victim_tag_o   ( victim_tag                                 )
  );

  llc_data_ways i_data_ways (
    .clk_i   ( clk_i                                 ),
    .en_i    ( data_en                               ),
    .we_i    ( data_we                               ),
    .way_i   ( data_way                              ),
    .index_i ( cpu_addr_i[BYTE_W+BLOCK_W +: INDEX_W] ),
    .block_i ( data_block                            ),
    .wdata_i ( data_wdata                            ),
    .rdata_o ( data_rdata                            )
  );

endmodule

// File: tests/llc_tb.sv
// cache testbench
// replays the golden operations on the CPU port against a memory model
// with random grant and read-data delays
`timescale 1ns/100ps

module llc_tb;
  import llc_pkg::*;

  localparam int MEM_WORDS = 32768;

  logic  clk_i, rst_n_i;
  logic  cpu_req_i, cpu_we_i, cpu_done_o;
  addr_t cpu_addr_i;
  data_t cpu_wdata_i, cpu_rdata_o;
  logic  mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  addr_t mem_addr_o;
  data_t mem_wdata_o, mem_rdata_i;

  data_t       mem [MEM_WORDS];
  logic [16:0] access_log [$];  // {we, addr} per granted access
  byte         op_code [$];
  byte         op_kind [$];     // h, m or e
  addr_t       op_addr [$];
  data_t       op_data [$];
  int          n_ops = 0;
  int          data_errors = 0;
  int          proto_errors = 0;
  integer      seed = 32'haff331c4;

  llc_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // memory model, grant after 0 to 3 cycles, read data 1 to 3 cycles after grant
  initial begin
    int          delay;
    logic [16:0] acc;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = data_t'(i) ^ 32'h5a5a0000;
    end
    forever begin
      @(negedge clk_i);
      if (rst_n_i && mem_req_o) begin
        delay = $random(seed) & 3;
        repeat (delay) @(negedge clk_i);
        acc = {mem_we_o, mem_addr_o};  // request is held until the grant
        access_log.push_back(acc);
        if (mem_we_o) begin
          mem[mem_addr_o[15:2]] = mem_wdata_o;
        end
        mem_gnt_i = 1'b1;
        @(negedge clk_i);
        mem_gnt_i = 1'b0;
        if (!acc[16]) begin
          delay = $unsigned($random(seed)) % 3;
          repeat (delay) @(negedge clk_i);
          mem_rdata_i  = mem[acc[15:2]];
          mem_rvalid_i = 1'b1;
          @(negedge clk_i);
          mem_rvalid_i = 1'b0;
        end
      end
    end
  end

  task automatic load_golden();
    int    fd;
    string line;
    byte   op;
    byte   kind;
    addr_t a;
    data_t d;
    fd = $fopen("tests/llc_golden.txt", "r");
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) != "#" && $sscanf(line, "%c %h %h %c", op, a, d, kind) == 4) begin
        op_code.push_back(op);
        op_addr.push_back(a);
        op_data.push_back(d);
        op_kind.push_back(kind);
      end
    end
    $fclose(fd);
    n_ops = op_addr.size();
  endtask

  // one CPU request, then its read data, hit latency and memory traffic
  task automatic run_op(input int k);
    int    cycles;
    int    n_wr;
    int    n_all;
    addr_t exp_a;
    addr_t mask;
    n_wr  = (op_kind[k] == "e") ? 4 : 0;
    n_all = (op_kind[k] == "h") ? 0 : n_wr + 4;
    access_log.delete();
    cpu_req_i   = 1'b1;
    cpu_we_i    = (op_code[k] == "w");
    cpu_addr_i  = op_addr[k];
    cpu_wdata_i = cpu_we_i ? op_data[k] : '0;
    cycles      = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!cpu_done_o);
    cpu_req_i = 1'b0;
    assert (cpu_we_i || cpu_rdata_o == op_data[k]) else begin
      $display("** Error: cpu_rdata_o at %h: got %h, expected %h",
               op_addr[k], cpu_rdata_o, op_data[k]);
      data_errors++;
    end
    assert (n_all != 0 || cycles == 3) else begin
      $display("hit at %h took %0d cycles instead of 3", op_addr[k], cycles);
      proto_errors++;
    end
    assert (access_log.size() == n_all) else begin
      $display("request at %h made %0d memory accesses instead of %0d",
               op_addr[k], access_log.size(), n_all);
      proto_errors++;
    end
    for (int i = 0; i < n_all && i < access_log.size(); i++) begin
      exp_a = {op_addr[k][15:4], 2'(i), 2'b00};
      mask  = (i < n_wr) ? 16'h00ff : 16'hffff;  // victim tag unknown, set and offset only
      assert ({access_log[i][16], access_log[i][15:0] & mask} == {i < n_wr, exp_a & mask})
      else begin
        $display("** Error: mem_we_o,mem_addr_o on access %0d at %h: got %h, expected %h",
                 i, op_addr[k], {access_log[i][16], access_log[i][15:0] & mask},
                 {i < n_wr, exp_a & mask});
        proto_errors++;
      end
    end
    @(negedge clk_i);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    cpu_req_i   = 1'b0;
    cpu_we_i    = 1'b0;
    cpu_addr_i  = '0;
    cpu_wdata_i = '0;
    load_golden();
    if (n_ops == 0) begin
      $display("no operations could be read from tests/llc_golden.txt");
      proto_errors++;
    end
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      assert (!cpu_done_o && !mem_req_o) else begin
        $display("** Error: cpu_done_o,mem_req_o after reset: got %h, expected 0",
                 {cpu_done_o, mem_req_o});
        proto_errors++;
      end
    end
    for (int k = 0; k < n_ops; k++) begin
      run_op(k);
    end
    $display("errors: %0d read data, %0d protocol", data_errors, proto_errors);
    if (data_errors + proto_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog, 200 cycles per golden operation
  initial begin
    wait (n_ops > 0);
    repeat (n_ops * 200) @(posedge clk_i);
    $display("timeout: the operations did not complete within %0d cycles", n_ops * 200);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: llc_top.f
verilog/llc_pkg.sv
verilog/llc_sram.sv
verilog/llc_tag_store.sv
verilog/llc_data_ways.sv
verilog/llc_block_cnt.sv
verilog/llc_ctrl.sv
verilog/llc_top.sv
tests/llc_tb.sv

// File: run.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module llc_tb -f llc_top.f -o llc_sim \
  && ./obj_dir/llc_sim | tee sim.log \
  || exit 1
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

// File: tests/llc_golden.txt
# op addr data kind: op is r or w, data is write data for w and expected read data for r
# kind is the expected memory traffic: h none, m one line refill, e line eviction then refill
r 0014 5a5a0005 m
r 0014 5a5a0005 h
w 0128 deadbeef m
r 0128 deadbeef h
r 0124 5a5a0049 h
r 012c 5a5a004b h
w 1030 11110000 m
w 1034 11110001 h
w 2030 22220000 m
w 3038 33330002 e
r 1030 11110000 e
r 1034 11110001 h
r 1038 5a5a040e h
r 2030 22220000 e
r 3038 33330002 m
r 4050 5a5a1014 m
r 5050 5a5a1414 m
r 4054 5a5a1015 h
r 6050 5a5a1814 m
r 4058 5a5a1016 h
r 5050 5a5a1414 m
w ff0c cafef00d m
r ff0c cafef00d h
